//--- imuldiv_config.svh
// width and timing constants for the iterative multiply/divide unit
// include wherever a module or package needs a width or a cycle bound

`ifndef IMULDIV_CONFIG_SVH
`define IMULDIV_CONFIG_SVH

// ----------------------------------------
// operand width
// ----------------------------------------

// both operands are signed words of this width
`define IMULDIV_XLEN 32

// ----------------------------------------
// iteration timing
// ----------------------------------------

// one iteration per operand bit
`define IMULDIV_ITERS `IMULDIV_XLEN

// bound from request accept to response valid
`define IMULDIV_RESP_MAX (`IMULDIV_ITERS + 2)

`endif

//--- imuldiv_div_iterative.sv
// iterative signed restoring divider, one quotient bit per cycle
// result packs {remainder, quotient}; val/rdy on both sides

`include "imuldiv_config.svh"

module imuldiv_div_iterative (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  req_a,
  input  imuldiv_pkg::word_t  req_b,
  input  logic                req_val,
  output logic                req_rdy,
  output imuldiv_pkg::dword_t result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  imuldiv_pkg::div_state_e state;
  imuldiv_pkg::count_t     count_reg;

  // dividend bits shift out the top while quotient bits shift in below
  imuldiv_pkg::word_t      quo_reg;
  // partial remainder
  imuldiv_pkg::word_t      rem_reg;
  // divisor magnitude
  imuldiv_pkg::word_t      dvs_reg;
  // original dividend, returned as remainder on divide by zero
  imuldiv_pkg::word_t      dividend_reg;
  logic                    quo_neg;
  logic                    rem_neg;
  logic                    dvs_zero;

  imuldiv_pkg::word_t      a_mag;
  imuldiv_pkg::word_t      b_mag;
  logic [`IMULDIV_XLEN:0]   rem_shift;
  logic [`IMULDIV_XLEN+1:0] diff;
  imuldiv_pkg::word_t      quo_fix;
  imuldiv_pkg::word_t      rem_fix;
  logic                    accept;
  logic                    last_iter;

  assign accept    = req_val && req_rdy;
  assign last_iter = (count_reg == '0);
  assign req_rdy   = (state == imuldiv_pkg::div_idle);
  assign resp_val  = (state == imuldiv_pkg::div_done);

  assign a_mag = req_a[`IMULDIV_XLEN-1] ? -req_a : req_a;
  assign b_mag = req_b[`IMULDIV_XLEN-1] ? -req_b : req_b;

  // ----------------------------------------
  // FSM and counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= imuldiv_pkg::div_idle;
      count_reg <= '0;
    end else begin
      case (state)
        imuldiv_pkg::div_idle: begin
          if (accept) begin
            state     <= imuldiv_pkg::div_calc;
            count_reg <= imuldiv_pkg::count_t'(`IMULDIV_ITERS - 1);
          end
        end
        imuldiv_pkg::div_calc: begin
          count_reg <= count_reg - 1'b1;
          if (last_iter) begin
            state <= imuldiv_pkg::div_done;
          end
        end
        imuldiv_pkg::div_done: begin
          // held here as long as resp_rdy stays low
          if (resp_val && resp_rdy) begin
            state <= imuldiv_pkg::div_idle;
          end
        end
        default: begin
          state <= imuldiv_pkg::div_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // restoring step
  // ----------------------------------------

  // bring the next dividend bit into the partial remainder
  assign rem_shift = {rem_reg, quo_reg[`IMULDIV_XLEN-1]};
  // extra top bit flags a negative difference
  assign diff      = {1'b0, rem_shift} - {2'b00, dvs_reg};

  always_ff @(posedge clk) begin
    if (accept) begin
      quo_reg      <= a_mag;
      rem_reg      <= '0;
      dvs_reg      <= b_mag;
      dividend_reg <= req_a;
      quo_neg      <= req_a[`IMULDIV_XLEN-1] ^ req_b[`IMULDIV_XLEN-1];
      rem_neg      <= req_a[`IMULDIV_XLEN-1];
      dvs_zero     <= (req_b == '0);
    end else if (state == imuldiv_pkg::div_calc) begin
      if (!diff[`IMULDIV_XLEN+1]) begin
        // divisor fits, keep the difference
        rem_reg <= diff[`IMULDIV_XLEN-1:0];
        quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], 1'b1};
      end else begin
        // restore, the shifted remainder is below the divisor
        rem_reg <= rem_shift[`IMULDIV_XLEN-1:0];
        quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], 1'b0};
      end
    end
  end

  // ----------------------------------------
  // sign fix and packing
  // ----------------------------------------

  // quotient truncates toward zero, remainder follows the dividend
  assign quo_fix = quo_neg ? -quo_reg : quo_reg;
  assign rem_fix = rem_neg ? -rem_reg : rem_reg;

  assign result = dvs_zero ? {dividend_reg, {`IMULDIV_XLEN{1'b1}}} : {rem_fix, quo_fix};

  // latency bound from accept to response
  resp_in_time: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##[1:`IMULDIV_RESP_MAX] resp_val)
    else $error("divider response late");

endmodule

//--- imuldiv_mul_ctrl.sv
// multiplier FSM: accepts a request, runs the iterations, holds the response
// drives the datapath through the ctrl modport of imuldiv_mul_ctrl_if

module imuldiv_mul_ctrl (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_val,
  output logic             req_rdy,
  output logic             resp_val,
  input  logic             resp_rdy,
  imuldiv_mul_ctrl_if.ctrl bus
);

  imuldiv_pkg::mul_state_e state;

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::mul_idle;
    end else begin
      case (state)
        imuldiv_pkg::mul_idle: begin
          if (req_val && req_rdy) begin
            state <= imuldiv_pkg::mul_calc;
          end
        end
        // the step taken with the counter at zero is the last one
        imuldiv_pkg::mul_calc: begin
          if (bus.last_iter) begin
            state <= imuldiv_pkg::mul_done;
          end
        end
        imuldiv_pkg::mul_done: begin
          if (resp_val && resp_rdy) begin
            state <= imuldiv_pkg::mul_idle;
          end
        end
        default: begin
          state <= imuldiv_pkg::mul_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    bus.load   = 1'b0;
    bus.step   = 1'b0;
    bus.add_en = 1'b0;
    case (state)
      imuldiv_pkg::mul_idle: begin
        req_rdy  = 1'b1;
        bus.load = req_val;
      end
      imuldiv_pkg::mul_calc: begin
        bus.step   = 1'b1;
        // add when the current multiplier bit is set
        bus.add_en = bus.b_lsb;
      end
      imuldiv_pkg::mul_done: begin
        resp_val = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // capture and iteration must not overlap in the datapath
  load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(bus.load && bus.step))
    else $error("load and step both high");

  // response is held until taken
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else $error("resp_val dropped before resp_rdy");

endmodule

//--- imuldiv_mul_ctrl_if.sv
// control strobes and status between the multiplier FSM and its datapath
// instantiate once in the multiplier wrapper and hand a modport to each side

interface imuldiv_mul_ctrl_if;

  // ----------------------------------------
  // control to datapath
  // ----------------------------------------

  // capture magnitudes and sign, clear accumulator, reload counter
  logic load;
  // shift operands and count down
  logic step;
  // accumulate operand A on this step
  logic add_en;

  // ----------------------------------------
  // datapath to control
  // ----------------------------------------

  // current multiplier bit
  logic b_lsb;
  // counter has reached zero
  logic last_iter;

  modport ctrl (output load, output step, output add_en, input b_lsb, input last_iter);

  modport dpath (input load, input step, input add_en, output b_lsb, output last_iter);

endinterface

//--- imuldiv_mul_dpath.sv
// shift-and-add multiplier datapath working on operand magnitudes
// strobed by imuldiv_mul_ctrl through the dpath modport

`include "imuldiv_config.svh"

module imuldiv_mul_dpath (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  req_a,
  input  imuldiv_pkg::word_t  req_b,
  output imuldiv_pkg::dword_t result,
  imuldiv_mul_ctrl_if.dpath   bus
);

  // multiplicand, widened so it can shift left 32 places
  imuldiv_pkg::dword_t a_reg;
  // multiplier, consumed from the low end
  imuldiv_pkg::word_t  b_reg;
  imuldiv_pkg::dword_t acc_reg;
  imuldiv_pkg::count_t count_reg;
  // set when exactly one operand is negative
  logic                sign_reg;

  imuldiv_pkg::word_t  a_mag;
  imuldiv_pkg::word_t  b_mag;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  // most negative value maps onto itself, which is the right unsigned magnitude
  assign a_mag = req_a[`IMULDIV_XLEN-1] ? -req_a : req_a;
  assign b_mag = req_b[`IMULDIV_XLEN-1] ? -req_b : req_b;

  // ----------------------------------------
  // iteration counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count_reg <= '0;
    end else if (bus.load) begin
      count_reg <= imuldiv_pkg::count_t'(`IMULDIV_ITERS - 1);
    end else if (bus.step) begin
      count_reg <= count_reg - 1'b1;
    end
  end

  assign bus.last_iter = (count_reg == '0);

  // ----------------------------------------
  // operands and accumulator
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (bus.load) begin
      a_reg    <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      b_reg    <= b_mag;
      acc_reg  <= '0;
      sign_reg <= req_a[`IMULDIV_XLEN-1] ^ req_b[`IMULDIV_XLEN-1];
    end else if (bus.step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
      // add only when control says so
      if (bus.add_en) begin
        acc_reg <= acc_reg + a_reg;
      end
    end
  end

  assign bus.b_lsb = b_reg[0];

  // ----------------------------------------
  // sign fix
  // ----------------------------------------

  // two's complement of the magnitude product
  assign result = sign_reg ? -acc_reg : acc_reg;

endmodule

//--- imuldiv_mul_iterative.sv
// iterative signed multiplier, full 64-bit product after 32 steps
// val/rdy on both request and response sides

module imuldiv_mul_iterative (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  req_a,
  input  imuldiv_pkg::word_t  req_b,
  input  logic                req_val,
  output logic                req_rdy,
  output imuldiv_pkg::dword_t result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  // strobes and status between the two halves
  imuldiv_mul_ctrl_if bus ();

  imuldiv_mul_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .bus      (bus.ctrl)
  );

  imuldiv_mul_dpath dpath (
    .clk    (clk),
    .reset  (reset),
    .req_a  (req_a),
    .req_b  (req_b),
    .result (result),
    .bus    (bus.dpath)
  );

endmodule

//--- imuldiv_pkg.sv
// shared types for the multiply/divide unit
// compile before every module that refers to imuldiv_pkg members

`include "imuldiv_config.svh"

package imuldiv_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------

  // one operand, or its magnitude
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // full product, or {remainder, quotient}
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;

  // counts iterations down to zero
  typedef logic [$clog2(`IMULDIV_ITERS)-1:0] count_t;

  // ----------------------------------------
  // encodings
  // ----------------------------------------

  // request function select
  typedef enum logic {fn_mul = 1'b0, fn_div = 1'b1} fn_e;

  typedef enum logic [1:0] {mul_idle = 2'd0, mul_calc = 2'd1, mul_done = 2'd2} mul_state_e;

  typedef enum logic [1:0] {div_idle = 2'd0, div_calc = 2'd1, div_done = 2'd2} div_state_e;

endpackage

//--- imuldiv_tb.sv
// testbench for imuldiv_top: directed and random multiply/divide requests
// checking is done by the concurrent assertions below; run with imuldiv_top.f

module imuldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // cycles from request transfer to resp_val high
  localparam int resp_latency = 33;
  // about 60 operations at no more than 45 cycles each
  localparam int max_cycles = 3000;

  logic                clk = 1'b0;
  logic                reset;
  imuldiv_pkg::fn_e    req_fn;
  imuldiv_pkg::word_t  req_a;
  imuldiv_pkg::word_t  req_b;
  logic                req_val;
  logic                req_rdy;
  imuldiv_pkg::dword_t resp_result;
  logic                resp_val;
  logic                resp_rdy;

  // request in flight, as seen from the handshakes
  logic                outstanding;
  imuldiv_pkg::dword_t exp_result;
  imuldiv_pkg::dword_t last_result;
  int                  lat;
  int                  n_req = 0;
  int                  n_resp = 0;
  int                  cycle = 0;
  int                  value_errs = 0;
  int                  protocol_errs = 0;
  int                  timeout_errs = 0;
  imuldiv_pkg::word_t  lcg_state;
  imuldiv_pkg::word_t  rnd;
  imuldiv_pkg::word_t  op_a;
  imuldiv_pkg::word_t  op_b;
  int                  i;

  always #2 clk = ~clk;

  imuldiv_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------
  // reference model and random source
  // ----------------------------------------

  // signed product, or {remainder, quotient} with the zero and overflow rules
  function automatic imuldiv_pkg::dword_t reference_result(input imuldiv_pkg::fn_e fn,
      input imuldiv_pkg::word_t a, input imuldiv_pkg::word_t b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] q;
    logic signed [31:0] r;
    sa = a;
    sb = b;
    wa = sa;
    wb = sb;
    if (fn == imuldiv_pkg::fn_mul) begin
      return wa * wb;
    end
    if (b == 32'h0) begin
      return {a, 32'hffff_ffff};
    end
    // most negative over minus one wraps back to itself
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return {32'h0, 32'h8000_0000};
    end
    // truncation toward zero, remainder follows the dividend
    q = sa / sb;
    r = sa % sb;
    return {r, q};
  endfunction

  function automatic imuldiv_pkg::word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ----------------------------------------
  // handshake tracking
  // ----------------------------------------

  always @(posedge clk) begin
    last_result <= resp_result;
    if (reset) begin
      outstanding <= 1'b0;
      lat         <= 0;
    end else if (req_val && req_rdy) begin
      outstanding <= 1'b1;
      exp_result  <= reference_result(req_fn, req_a, req_b);
      lat         <= 1;
      n_req       <= n_req + 1;
    end else if (resp_val && resp_rdy) begin
      outstanding <= 1'b0;
      n_resp      <= n_resp + 1;
    end else if (outstanding && !resp_val) begin
      lat <= lat + 1;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  result_check: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> resp_result == exp_result)
    else begin
      value_errs++;
      $display("[FAIL] resp_result expected %h got %h",
        $sampled(exp_result), $sampled(resp_result));
    end

  // back-pressure keeps the response up and unchanged
  hold_valid: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else begin
      protocol_errs++;
      $display("resp_val dropped while resp_rdy was low");
    end

  hold_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_result == last_result)
    else begin
      value_errs++;
      $display("[FAIL] resp_result expected %h got %h",
        $sampled(last_result), $sampled(resp_result));
    end

  rdy_while_busy: assert property (@(posedge clk) disable iff (reset)
    outstanding |-> !req_rdy)
    else begin
      protocol_errs++;
      $display("req_rdy high while a request is in flight");
    end

  // a response with nothing in flight would be a duplicate
  single_resp: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> outstanding)
    else begin
      protocol_errs++;
      $display("response delivered with no request in flight");
    end

  latency_check: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> lat == resp_latency)
    else begin
      protocol_errs++;
      $display("resp_val rose %0d cycles after the request instead of %0d",
        $sampled(lat), resp_latency);
    end

  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> !resp_val && req_rdy)
    else begin
      protocol_errs++;
      $display("after reset resp_val is not low or req_rdy is not high");
    end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  // one request and its response; stall cycles of resp_rdy low after resp_val
  task automatic run_op(input imuldiv_pkg::fn_e fn, input imuldiv_pkg::word_t a,
      input imuldiv_pkg::word_t b, input int stall);
    int k;
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    @(posedge clk);
    #1;
    req_val = 1'b0;
    while (!resp_val) begin
      @(posedge clk);
      #1;
    end
    for (k = 0; k < stall; k++) begin
      @(posedge clk);
      #1;
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
  endtask

  task automatic show_error_counts();
    $display("errors: value %0d, protocol %0d, timeout %0d, requests %0d, responses %0d",
      value_errs, protocol_errs, timeout_errs, n_req, n_resp);
  endtask

  // run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > max_cycles) begin
      timeout_errs = 1;
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      show_error_counts();
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    reset     = 1'b1;
    req_fn    = imuldiv_pkg::fn_mul;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b1;
    lcg_state = 32'd30;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // directed multiplies
    run_op(imuldiv_pkg::fn_mul, 32'h0, 32'h1234_5678, 0);
    run_op(imuldiv_pkg::fn_mul, 32'h1, 32'hdead_beef, 0);
    run_op(imuldiv_pkg::fn_mul, 32'hffff_ffff, 32'h0000_1234, 0);
    run_op(imuldiv_pkg::fn_mul, 32'h0001_0003, 32'hffff_fff9, 0);
    run_op(imuldiv_pkg::fn_mul, 32'hffff_8000, 32'hfffe_0001, 0);
    run_op(imuldiv_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000, 0);
    run_op(imuldiv_pkg::fn_mul, 32'h7fff_ffff, 32'h7fff_ffff, 0);

    // signed division in all four sign cases, then the overflow case
    run_op(imuldiv_pkg::fn_div, 32'd7, 32'd2, 0);
    run_op(imuldiv_pkg::fn_div, 32'hffff_fff9, 32'd2, 0);
    run_op(imuldiv_pkg::fn_div, 32'd7, 32'hffff_fffe, 0);
    run_op(imuldiv_pkg::fn_div, 32'hffff_fff9, 32'hffff_fffe, 0);
    run_op(imuldiv_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff, 0);

    // divide by zero with positive, negative and zero dividends
    run_op(imuldiv_pkg::fn_div, 32'd12345, 32'h0, 0);
    run_op(imuldiv_pkg::fn_div, 32'hffff_cfc7, 32'h0, 0);
    run_op(imuldiv_pkg::fn_div, 32'h0, 32'h0, 0);

    // random stretches of back-pressure
    for (i = 0; i < 5; i++) begin
      rnd  = next_rand();
      op_a = next_rand();
      op_b = next_rand();
      run_op(imuldiv_pkg::fn_e'(rnd[31]), op_a, op_b, 1 + (rnd[27:20] % 7));
    end

    // random function and operands
    for (i = 0; i < 40; i++) begin
      rnd  = next_rand();
      op_a = next_rand();
      op_b = next_rand();
      // narrow some divisors so quotients spread out
      if (rnd[30]) begin
        op_b = op_b >> rnd[28:24];
      end
      run_op(imuldiv_pkg::fn_e'(rnd[31]), op_a, op_b, 0);
    end

    repeat (2) @(posedge clk);
    #1;
    count_match: assert (n_req == n_resp)
      else begin
        protocol_errs++;
        $display("%0d requests but %0d responses", n_req, n_resp);
      end
    show_error_counts();
    if (value_errs + protocol_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- imuldiv_top.f
+incdir+.
imuldiv_pkg.sv
imuldiv_mul_ctrl_if.sv
imuldiv_mul_dpath.sv
imuldiv_mul_ctrl.sv
imuldiv_mul_iterative.sv
imuldiv_div_iterative.sv
imuldiv_top.sv
imuldiv_tb.sv

//--- imuldiv_top.sv
// multiply/divide unit top: steers each request by function to one unit
// one request in flight; the response comes back from the unit that took it

module imuldiv_top (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::fn_e    req_fn,
  input  imuldiv_pkg::word_t  req_a,
  input  imuldiv_pkg::word_t  req_b,
  input  logic                req_val,
  output logic                req_rdy,
  output imuldiv_pkg::dword_t resp_result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  logic                busy;
  // function of the request in flight
  imuldiv_pkg::fn_e    fn_q;

  logic                mul_req_val;
  logic                mul_req_rdy;
  imuldiv_pkg::dword_t mul_result;
  logic                mul_resp_val;
  logic                mul_resp_rdy;

  logic                div_req_val;
  logic                div_req_rdy;
  imuldiv_pkg::dword_t div_result;
  logic                div_resp_val;
  logic                div_resp_rdy;

  // ----------------------------------------
  // request side
  // ----------------------------------------

  assign req_rdy = !busy;

  assign mul_req_val = req_val && !busy && (req_fn == imuldiv_pkg::fn_mul);
  assign div_req_val = req_val && !busy && (req_fn == imuldiv_pkg::fn_div);

  // set on request transfer, cleared on response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      fn_q <= imuldiv_pkg::fn_mul;
    end else if (req_val && req_rdy) begin
      busy <= 1'b1;
      fn_q <= req_fn;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  imuldiv_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req_a    (req_a),
    .req_b    (req_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req_a    (req_a),
    .req_b    (req_b),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .result   (div_result),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  // ----------------------------------------
  // response side
  // ----------------------------------------

  assign resp_val    = (fn_q == imuldiv_pkg::fn_mul) ? mul_resp_val : div_resp_val;
  assign resp_result = (fn_q == imuldiv_pkg::fn_mul) ? mul_result : div_result;

  assign mul_resp_rdy = resp_rdy && (fn_q == imuldiv_pkg::fn_mul);
  assign div_resp_rdy = resp_rdy && (fn_q == imuldiv_pkg::fn_div);

  // only the unit holding the request may answer
  one_resp: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val))
    else $error("both units have resp_val high");

  // an idle top means both units are back in idle
  idle_units: assert property (@(posedge clk) disable iff (reset)
    !busy |-> mul_req_rdy && div_req_rdy)
    else $error("unit not ready while top is idle");

endmodule
